/* Makefile */
# Verilator simulation of the non-computational SIMD slice
TOP := noncomp_slice_tb

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

/* flist.f */
verilog/simd_fp_pkg.sv
verilog/pipe_ctrl.sv
verilog/noncomp_lane.sv
verilog/lane_merge.sv
verilog/noncomp_slice.sv
verification/noncomp_slice_checker.sv
verification/noncomp_slice_tb.sv

/* verification/noncomp_slice_checker.sv */
// ------------------------------
// Slice handshake assertions
// ------------------------------

module noncomp_slice_checker #(
  parameter int unsigned TagWidth = 4
) (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          in_ready_o,
  input logic                          out_ready_i,
  input logic                          out_valid_o,
  input logic                          busy_o,
  input logic [simd_fp_pkg::WIDTH-1:0] result_o,
  input logic [TagWidth-1:0]           tag_o
);

  // Pipeline comes out of reset empty
  reset_empty: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !out_valid_o && !busy_o)
    else $error("Output valid or busy set right after reset");

  // A stalled result must not change under the consumer
  stall_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(tag_o))
    else $error("Result or tag changed while the output was stalled");

  // A draining consumer never blocks the input
  ready_through: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_ready_i |-> in_ready_o)
    else $error("Input not ready while the output was ready");

endmodule

bind noncomp_slice noncomp_slice_checker #(
  .TagWidth ( TagWidth )
) u_checker (
  .clk_i,
  .rst_n_i,
  .in_ready_o,
  .out_ready_i,
  .out_valid_o,
  .busy_o,
  .result_o,
  .tag_o
);

/* verification/noncomp_slice_tb.sv */
// ------------------------------
// Non-computational slice testbench
// ------------------------------

module noncomp_slice_tb;
  import simd_fp_pkg::*;

  localparam int CLK_PERIOD      = 100;
  localparam int TAG_W           = 4;
  localparam int NUM_ENTRIES     = 21;
  localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 20;
  localparam status_t ST_NV      = 5'b10000;
  localparam status_t ST_CLR     = 5'b00000;

  typedef struct packed {
    operation_e  op;
    fp_format_e  fmt;
    logic        vec;
    logic [1:0]  mask;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    status_t     st;
  } entry_t;

  logic clk_i, rst_n_i, in_valid_i, out_ready_i, vectorial_i;
  logic in_ready_o, out_valid_o, busy_o;
  operand_u operands_a_i, operands_b_i;
  operation_e op_i;
  fp_format_e fmt_i;
  logic [NUM_LANES-1:0] simd_mask_i;
  logic [TAG_W-1:0] tag_i, tag_o;
  logic [WIDTH-1:0] result_o;
  status_t status_o;

  entry_t tbl [NUM_ENTRIES];
  int     n_loaded;
  int     expected_q [$];  // Table indices in issue order
  int     done_count;

  noncomp_slice uut (.*);

  task automatic abort_run();
    $display("TESTS FAILED");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic add_entry(input operation_e op, input fp_format_e fmt, input logic vec,
                           input logic [1:0] mask, input logic [31:0] a, input logic [31:0] b,
                           input logic [31:0] res, input status_t st);
    tbl[n_loaded].op   = op;
    tbl[n_loaded].fmt  = fmt;
    tbl[n_loaded].vec  = vec;
    tbl[n_loaded].mask = mask;
    tbl[n_loaded].a    = a;
    tbl[n_loaded].b    = b;
    tbl[n_loaded].res  = res;
    tbl[n_loaded].st   = st;
    n_loaded++;
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic load_table();
    add_entry(SGNJ,  FP32, 0, 2'b11, 32'h3fc0_0000, 32'hc000_0000, 32'hbfc0_0000, ST_CLR);
    add_entry(SGNJN, FP32, 0, 2'b11, 32'h3fc0_0000, 32'hc000_0000, 32'h3fc0_0000, ST_CLR);
    add_entry(SGNJX, FP32, 0, 2'b11, 32'hbfc0_0000, 32'hc000_0000, 32'h3fc0_0000, ST_CLR);
    add_entry(FMIN,  FP32, 0, 2'b01, 32'h3fc0_0000, 32'hc000_0000, 32'hc000_0000, ST_CLR);
    add_entry(FMAX,  FP32, 0, 2'b01, 32'h3fc0_0000, 32'hc000_0000, 32'h3fc0_0000, ST_CLR);
    add_entry(FMIN,  FP32, 0, 2'b11, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000, ST_CLR);
    add_entry(FMAX,  FP32, 0, 2'b11, 32'h8000_0000, 32'h0000_0000, 32'h0000_0000, ST_CLR);
    add_entry(FMIN,  FP32, 0, 2'b11, 32'h7fc0_0001, 32'h4040_0000, 32'h4040_0000, ST_CLR);
    add_entry(FMAX,  FP32, 0, 2'b11, 32'hffc0_0123, 32'h7fc0_0001, 32'h7fc0_0000, ST_CLR);
    add_entry(FMIN,  FP32, 0, 2'b11, 32'h7f80_0001, 32'h3f80_0000, 32'h3f80_0000, ST_NV);
    add_entry(FMAX,  FP32, 0, 2'b11, 32'hc040_0000, 32'hbf80_0000, 32'hbf80_0000, ST_CLR);
    // Vectorial FP32 runs as scalar, upper half holds an FP16 signaling NaN
    add_entry(FMIN,  FP32, 1, 2'b11, 32'h7c01_0000, 32'h3f80_0000, 32'h3f80_0000, ST_CLR);
    // Scalar FP16 with the upper half of the result NaN-boxed
    add_entry(SGNJN, FP16, 0, 2'b11, 32'habcd_3c00, 32'h0000_3c00, 32'hffff_bc00, ST_CLR);
    add_entry(FMAX,  FP16, 0, 2'b11, 32'h1234_c000, 32'h5678_4200, 32'hffff_4200, ST_CLR);
    add_entry(FMIN,  FP16, 0, 2'b11, 32'h0000_7e01, 32'h0000_fc01, 32'hffff_7e00, ST_NV);
    // Vectorial FP16 on two independent lanes
    add_entry(SGNJX, FP16, 1, 2'b11, 32'h3c00_c000, 32'h8000_8000, 32'hbc00_4000, ST_CLR);
    add_entry(FMIN,  FP16, 1, 2'b11, 32'h4200_3c00, 32'h4000_4400, 32'h4000_3c00, ST_CLR);
    add_entry(FMAX,  FP16, 1, 2'b01, 32'h7c01_3c00, 32'h4000_4000, 32'h4000_4000, ST_CLR);
    add_entry(FMAX,  FP16, 1, 2'b11, 32'h7c01_3c00, 32'h4000_4000, 32'h4000_4000, ST_NV);
    add_entry(FMAX,  FP16, 1, 2'b10, 32'h3c00_7c01, 32'h4000_4000, 32'h4000_4000, ST_CLR);
    add_entry(FMIN,  FP16, 1, 2'b11, 32'h8000_0000, 32'h0000_8000, 32'h8000_8000, ST_CLR);
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Random back-pressure at about 70 percent ready
  initial begin : back_pressure
    void'($urandom(32'h974c_220b));
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      out_ready_i <= ($urandom % 100) < 70;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout after %0d cycles, not all results came out", WATCHDOG_CYCLES);
    abort_run();
  end

  // ------------------------------
  // Output monitor
  // ------------------------------
  always @(posedge clk_i) begin : monitor
    int idx;
    if (rst_n_i && out_valid_o && out_ready_i) begin
      if (expected_q.size() == 0) begin
        $display("Output transfer at time %0t with no request outstanding", $time);
        abort_run();
      end else begin
        idx = expected_q.pop_front();
        assert (result_o == tbl[idx].res) else begin
          $display("MISMATCH time=%0t entry %0d result got %h expected %h",
                   $time, idx, result_o, tbl[idx].res);
          abort_run();
        end
        assert (status_o == tbl[idx].st) else begin
          $display("MISMATCH time=%0t entry %0d status got %b expected %b",
                   $time, idx, status_o, tbl[idx].st);
          abort_run();
        end
        assert (tag_o == TAG_W'(idx)) else begin
          $display("MISMATCH time=%0t entry %0d tag got %0d expected %0d",
                   $time, idx, tag_o, TAG_W'(idx));
          abort_run();
        end
        done_count++;
      end
    end
  end

  // ------------------------------
  // Driver
  // ------------------------------
  initial begin : driver
    rst_n_i      = 1'b0;
    in_valid_i   = 1'b0;
    operands_a_i = '0;
    operands_b_i = '0;
    op_i         = SGNJ;
    fmt_i        = FP32;
    vectorial_i  = 1'b0;
    simd_mask_i  = '0;
    tag_i        = '0;
    n_loaded     = 0;
    done_count   = 0;
    load_table();

    repeat (2) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    for (int i = 0; i < NUM_ENTRIES; i++) begin
      operands_a_i <= tbl[i].a;
      operands_b_i <= tbl[i].b;
      op_i         <= tbl[i].op;
      fmt_i        <= tbl[i].fmt;
      vectorial_i  <= tbl[i].vec;
      simd_mask_i  <= tbl[i].mask;
      tag_i        <= TAG_W'(i);
      in_valid_i   <= 1'b1;
      expected_q.push_back(i);
      @(posedge clk_i);
      while (!in_ready_o) @(posedge clk_i);  // Hold until accepted
    end
    in_valid_i <= 1'b0;

    wait (done_count == NUM_ENTRIES);
    @(posedge clk_i);
    if (!busy_o && !out_valid_o) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      $display("Pipeline still holds data after the last expected result");
      abort_run();
    end
  end

endmodule

/* verilog/lane_merge.sv */
// ------------------------------
// Lane result merge
// ------------------------------

module lane_merge (
  input  logic [simd_fp_pkg::NUM_LANES-1:0][simd_fp_pkg::WIDTH-1:0] lane_result_i,
  input  simd_fp_pkg::status_t [simd_fp_pkg::NUM_LANES-1:0]         lane_status_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0]                         lane_mask_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0]                         lane_active_i,
  input  simd_fp_pkg::fp_format_e                                   fmt_i,
  output logic [simd_fp_pkg::WIDTH-1:0]                             result_o,
  output simd_fp_pkg::status_t                                      status_o
);
  import simd_fp_pkg::*;

  operand_u merged;

  // ------------------------------
  // Result packing
  // ------------------------------
  always_comb begin : pack_result
    if (fmt_i == FP32) begin
      merged.fp32 = lane_result_i[0];
    end else begin
      merged.fp16[0] = lane_result_i[0][FP16_WIDTH-1:0];
      // Unused upper half is NaN-boxed
      if (lane_active_i[1]) begin
        merged.fp16[1] = lane_result_i[1][FP16_WIDTH-1:0];
      end else begin
        merged.fp16[1] = '1;
      end
    end
  end

  assign result_o = merged.fp32;

  // Masked-off or idle lanes contribute no flags
  always_comb begin : collapse_status
    status_t acc;
    acc = '0;
    for (int i = 0; i < int'(NUM_LANES); i++) begin
      if (lane_active_i[i]) begin
        acc = acc | (lane_status_i[i] & {$bits(status_t){lane_mask_i[i]}});
      end
    end
    status_o = acc;
  end

endmodule

/* verilog/noncomp_lane.sv */
// ------------------------------
// Sign injection / min-max lane
// ------------------------------

module noncomp_lane #(
  parameter simd_fp_pkg::fmt_logic_t LaneFormats = '1,
  parameter int unsigned             NumPipeRegs = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic [simd_fp_pkg::WIDTH-1:0] a_i,
  input  logic [simd_fp_pkg::WIDTH-1:0] b_i,
  input  simd_fp_pkg::operation_e       op_i,
  input  simd_fp_pkg::fp_format_e       fmt_i,
  input  logic                          mask_i,
  input  logic [NumPipeRegs-1:0]        reg_enable_i,
  output logic [simd_fp_pkg::WIDTH-1:0] result_o,
  output simd_fp_pkg::status_t          status_o,
  output logic                          mask_o
);
  import simd_fp_pkg::*;

  logic             use_fp32;
  logic             a_sign, b_sign;
  logic [WIDTH-2:0] a_mag, b_mag;
  logic             a_nan, b_nan, a_snan, b_snan;
  logic             a_lt_b, pick_b, is_minmax;
  logic             res_sign;
  logic [WIDTH-2:0] res_mag;
  logic [WIDTH-1:0] op_result;
  status_t          op_status;

  // An FP16-only lane always decodes its slice as FP16
  assign use_fp32 = LaneFormats[FP32] & ((fmt_i == FP32) | ~LaneFormats[FP16]);

  // ------------------------------
  // Operand classification
  // ------------------------------
  always_comb begin : classify
    if (use_fp32) begin
      a_sign = a_i[31];
      b_sign = b_i[31];
      a_mag  = a_i[30:0];
      b_mag  = b_i[30:0];
      a_nan  = (&a_i[30:23]) & (|a_i[22:0]);
      b_nan  = (&b_i[30:23]) & (|b_i[22:0]);
      a_snan = a_nan & ~a_i[22];  // Quiet bit clear
      b_snan = b_nan & ~b_i[22];
    end else begin
      a_sign = a_i[15];
      b_sign = b_i[15];
      a_mag  = {{(WIDTH-FP16_WIDTH){1'b0}}, a_i[14:0]};
      b_mag  = {{(WIDTH-FP16_WIDTH){1'b0}}, b_i[14:0]};
      a_nan  = (&a_i[14:10]) & (|a_i[9:0]);
      b_nan  = (&b_i[14:10]) & (|b_i[9:0]);
      a_snan = a_nan & ~a_i[9];
      b_snan = b_nan & ~b_i[9];
    end
  end

  // Sign-magnitude ordering, -0 sorts below +0
  always_comb begin : order
    if (a_sign != b_sign) begin
      a_lt_b = a_sign;
    end else if (a_sign) begin
      a_lt_b = a_mag > b_mag;  // Both negative, larger magnitude is smaller
    end else begin
      a_lt_b = a_mag < b_mag;
    end
  end

  assign is_minmax = (op_i == FMIN) | (op_i == FMAX);

  always_comb begin : select_operand
    pick_b = (op_i == FMIN) ? ~a_lt_b : a_lt_b;
    if (a_nan & ~b_nan) pick_b = 1'b1;  // A NaN loses to a number
    if (b_nan & ~a_nan) pick_b = 1'b0;
  end

  always_comb begin : compute
    op_status = '0;
    res_sign  = a_sign;
    res_mag   = a_mag;
    case (op_i)
      SGNJ:  res_sign = b_sign;
      SGNJN: res_sign = ~b_sign;
      SGNJX: res_sign = a_sign ^ b_sign;
      FMIN, FMAX: begin
        res_sign     = pick_b ? b_sign : a_sign;
        res_mag      = pick_b ? b_mag : a_mag;
        op_status.nv = a_snan | b_snan;
      end
      default: ;
    endcase
    if (use_fp32) begin
      op_result = {res_sign, res_mag};
    end else begin
      op_result = {{FP16_WIDTH{1'b0}}, res_sign, res_mag[FP16_WIDTH-2:0]};
    end
    if (is_minmax && a_nan && b_nan) begin
      op_result = use_fp32 ? FP32_QNAN : {{FP16_WIDTH{1'b0}}, FP16_QNAN};
    end
  end

  // ------------------------------
  // Register stages
  // ------------------------------
  logic [WIDTH-1:0] stage_result [0:NumPipeRegs];
  status_t          stage_status [0:NumPipeRegs];
  logic             stage_mask   [0:NumPipeRegs];

  assign stage_result[0] = op_result;
  assign stage_status[0] = op_status;
  assign stage_mask[0]   = mask_i;

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    always_ff @(posedge clk_i) begin
      if (reg_enable_i[i]) stage_result[i+1] <= stage_result[i];
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        stage_status[i+1] <= '0;
        stage_mask[i+1]   <= 1'b0;
      end else if (reg_enable_i[i]) begin
        stage_status[i+1] <= stage_status[i];
        stage_mask[i+1]   <= stage_mask[i];
      end
    end
  end

  assign result_o = stage_result[NumPipeRegs];
  assign status_o = stage_status[NumPipeRegs];
  assign mask_o   = stage_mask[NumPipeRegs];

endmodule

/* verilog/noncomp_slice.sv */
// ------------------------------
// Non-computational SIMD slice
// ------------------------------

module noncomp_slice #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  simd_fp_pkg::operand_u             operands_a_i,
  input  simd_fp_pkg::operand_u             operands_b_i,
  input  simd_fp_pkg::operation_e           op_i,
  input  simd_fp_pkg::fp_format_e           fmt_i,
  input  logic                              vectorial_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] simd_mask_i,
  input  logic [TagWidth-1:0]               tag_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  output logic [simd_fp_pkg::WIDTH-1:0]     result_o,
  output simd_fp_pkg::status_t              status_o,
  output logic [TagWidth-1:0]               tag_o,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o
);
  import simd_fp_pkg::*;

  logic [NUM_LANES-1:0]              in_lane_active, out_lane_active;
  logic [NumPipeRegs-1:0]            reg_enable;
  fp_format_e                        out_fmt;
  logic [NUM_LANES-1:0][WIDTH-1:0]   lane_result;
  status_t [NUM_LANES-1:0]           lane_status;
  logic [NUM_LANES-1:0]              lane_mask;

  // Upper lane only works on vectorial FP16
  assign in_lane_active[0] = 1'b1;
  assign in_lane_active[1] = vectorial_i & (fmt_i == FP16);

  pipe_ctrl #(
    .NumPipeRegs ( NumPipeRegs ),
    .TagWidth    ( TagWidth    )
  ) i_pipe_ctrl (
    .clk_i,
    .rst_n_i,
    .in_valid_i,
    .in_ready_o,
    .tag_i,
    .fmt_i,
    .lane_active_i ( in_lane_active  ),
    .out_valid_o,
    .out_ready_i,
    .busy_o,
    .tag_o,
    .fmt_o         ( out_fmt         ),
    .lane_active_o ( out_lane_active ),
    .reg_enable_o  ( reg_enable      )
  );

  // ------------------------------
  // Lanes
  // ------------------------------
  for (genvar lane = 0; lane < int'(NUM_LANES); lane++) begin : gen_lanes
    localparam fmt_logic_t LANE_FORMATS = (lane == 0) ? 2'b11 : 2'b10;  // Upper lanes FP16 only

    logic [WIDTH-1:0] lane_a, lane_b;

    if (lane == 0) begin : gen_full_word
      assign lane_a = operands_a_i.fp32;
      assign lane_b = operands_b_i.fp32;
    end else begin : gen_half_word
      assign lane_a = {{(WIDTH-FP16_WIDTH){1'b0}}, operands_a_i.fp16[lane]};
      assign lane_b = {{(WIDTH-FP16_WIDTH){1'b0}}, operands_b_i.fp16[lane]};
    end

    noncomp_lane #(
      .LaneFormats ( LANE_FORMATS ),
      .NumPipeRegs ( NumPipeRegs  )
    ) i_lane (
      .clk_i,
      .rst_n_i,
      .a_i          ( lane_a            ),
      .b_i          ( lane_b            ),
      .op_i,
      .fmt_i,
      .mask_i       ( simd_mask_i[lane] ),
      .reg_enable_i ( reg_enable        ),
      .result_o     ( lane_result[lane] ),
      .status_o     ( lane_status[lane] ),
      .mask_o       ( lane_mask[lane]   )
    );
  end

  lane_merge i_lane_merge (
    .lane_result_i ( lane_result     ),
    .lane_status_i ( lane_status     ),
    .lane_mask_i   ( lane_mask       ),
    .lane_active_i ( out_lane_active ),
    .fmt_i         ( out_fmt         ),
    .result_o,
    .status_o
  );

endmodule

/* verilog/pipe_ctrl.sv */
// ------------------------------
// Pipeline handshake control
// ------------------------------

module pipe_ctrl #(
  parameter int unsigned NumPipeRegs = 2,
  parameter int unsigned TagWidth    = 4
) (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              in_valid_i,
  output logic                              in_ready_o,
  input  logic [TagWidth-1:0]               tag_i,
  input  simd_fp_pkg::fp_format_e           fmt_i,
  input  logic [simd_fp_pkg::NUM_LANES-1:0] lane_active_i,
  output logic                              out_valid_o,
  input  logic                              out_ready_i,
  output logic                              busy_o,
  output logic [TagWidth-1:0]               tag_o,
  output simd_fp_pkg::fp_format_e           fmt_o,
  output logic [simd_fp_pkg::NUM_LANES-1:0] lane_active_o,
  output logic [NumPipeRegs-1:0]            reg_enable_o
);
  import simd_fp_pkg::*;

  // Index i holds the request after i register stages
  logic                 stage_valid  [0:NumPipeRegs];
  logic                 stage_ready  [0:NumPipeRegs];
  logic [TagWidth-1:0]  stage_tag    [0:NumPipeRegs];
  fp_format_e           stage_fmt    [0:NumPipeRegs];
  logic [NUM_LANES-1:0] stage_active [0:NumPipeRegs];

  assign stage_valid[0]  = in_valid_i;
  assign stage_tag[0]    = tag_i;
  assign stage_fmt[0]    = fmt_i;
  assign stage_active[0] = lane_active_i;

  assign stage_ready[NumPipeRegs] = out_ready_i;  // Last stage drains into the consumer

  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stages
    // Stage i may hand over when the next one is empty or moving on
    assign stage_ready[i]  = stage_ready[i+1] | ~stage_valid[i+1];
    assign reg_enable_o[i] = stage_valid[i] & stage_ready[i];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        stage_valid[i+1] <= 1'b0;
      end else if (stage_ready[i]) begin
        stage_valid[i+1] <= stage_valid[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (reg_enable_o[i]) begin
        stage_tag[i+1]    <= stage_tag[i];
        stage_fmt[i+1]    <= stage_fmt[i];
        stage_active[i+1] <= stage_active[i];
      end
    end
  end

  if (NumPipeRegs == 0) begin : gen_no_stages
    assign reg_enable_o = '0;
  end

  // Something in flight in any register stage
  always_comb begin : busy_collapse
    busy_o = 1'b0;
    for (int i = 1; i <= int'(NumPipeRegs); i++) begin
      busy_o = busy_o | stage_valid[i];
    end
  end

  assign in_ready_o    = stage_ready[0];
  assign out_valid_o   = stage_valid[NumPipeRegs];
  assign tag_o         = stage_tag[NumPipeRegs];
  assign fmt_o         = stage_fmt[NumPipeRegs];
  assign lane_active_o = stage_active[NumPipeRegs];

endmodule

/* verilog/simd_fp_pkg.sv */
// ------------------------------
// SIMD FP slice shared types
// ------------------------------

package simd_fp_pkg;

  // ------------------------------
  // Datapath geometry
  // ------------------------------
  localparam int unsigned WIDTH      = 32;
  localparam int unsigned NUM_LANES  = 2;
  localparam int unsigned FP16_WIDTH = 16;

  // Float format of a request
  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  // One bit per format, indexed by fp_format_e
  typedef logic [1:0] fmt_logic_t;

  // Non-computational operations
  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } operation_e;

  // Exception flags, NV in the MSB
  typedef struct packed {
    logic nv;  // Invalid operation
    logic dz;  // Divide by zero
    logic of;  // Overflow
    logic uf;  // Underflow
    logic nx;  // Inexact
  } status_t;

  // One operand word seen either as a single FP32 or two packed FP16
  typedef union packed {
    logic [WIDTH-1:0]                 fp32;
    logic [1:0][FP16_WIDTH-1:0]       fp16;  // Index 0 is the low half
  } operand_u;

  // ------------------------------
  // Canonical quiet NaNs
  // ------------------------------
  localparam logic [WIDTH-1:0]      FP32_QNAN = 32'h7fc0_0000;
  localparam logic [FP16_WIDTH-1:0] FP16_QNAN = 16'h7e00;

endpackage
